//--- include/raster_settings.svh
// Build-time sizes for the raster subsystem
// Include wherever frame geometry, panel clock divider or sync depth is needed
`ifndef RASTER_SETTINGS_SVH
`define RASTER_SETTINGS_SVH

// Frame geometry in pixels
`define RASTER_X_RES 16
`define RASTER_Y_RES 8
`define RASTER_PIXELS (`RASTER_X_RES * `RASTER_Y_RES)

// clk cycles per half period of the panel sck
`define RASTER_SPI_DIV 2

// Flops on each asynchronous host serial input
`define RASTER_SYNC_STAGES 2

`endif

//--- design/raster_pkg.sv
// Types shared by the raster RTL blocks
// Pull in with a wildcard import in the module header
`include "raster_settings.svh"

package raster_pkg;

    // RGB565 color
    typedef logic [15:0] pixel_t;

    // One host command word
    typedef logic [31:0] cmd_word_t;

    // Opcode field, bits 31..24 of a header word
    typedef enum logic [7:0] {
        OP_CLEAR = 8'h01,
        OP_RECT  = 8'h02,
        OP_FLUSH = 8'h03
    } opcode_e;

    // Pixel address, row * X_RES + column
    typedef logic [$clog2(`RASTER_PIXELS)-1:0] addr_t;

endpackage

//--- design/serial_cmd_rx.sv
// Host serial slave, assembles 32-bit command words MSB first
// Holds each finished word on a valid/ready port, serial_cts low while held
`timescale 1ns/10ps
`include "raster_settings.svh"

module serial_cmd_rx
    import raster_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      serial_mosi,
    input  logic      serial_sck,
    input  logic      serial_cs,
    output logic      serial_cts,
    output logic      cmd_valid,
    output cmd_word_t cmd_data,
    input  logic      cmd_ready
);
    localparam int SYNC = `RASTER_SYNC_STAGES;

    logic [SYNC-1:0] mosi_sync;
    logic [SYNC-1:0] sck_sync;
    logic [SYNC-1:0] cs_sync;
    logic            sck_prev;
    logic            sck_rise;
    logic            cs_high;
    logic            word_done;
    logic [4:0]      bit_cnt;
    cmd_word_t       shift_q;
    cmd_word_t       shift_next;

    ////////////////////////////////////////////////////////////
    // Input synchronizers and edge detect
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mosi_sync <= '0;
            sck_sync  <= '0;
            // Deselected until proven otherwise
            cs_sync   <= '1;
            sck_prev  <= 1'b0;
        end
        else
        begin
            mosi_sync <= {mosi_sync[SYNC-2:0], serial_mosi};
            sck_sync  <= {sck_sync[SYNC-2:0], serial_sck};
            cs_sync   <= {cs_sync[SYNC-2:0], serial_cs};
            sck_prev  <= sck_sync[SYNC-1];
        end
    end

    assign sck_rise   = sck_sync[SYNC-1] & ~sck_prev;
    assign cs_high    = cs_sync[SYNC-1];
    // All three lines share the same sync depth, so bits stay aligned
    assign shift_next = {shift_q[30:0], mosi_sync[SYNC-1]};
    assign word_done  = sck_rise & ~cs_high & (bit_cnt == 5'd31);

    ////////////////////////////////////////////////////////////
    // Bit counter and word handshake
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt   <= '0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                cmd_valid <= 1'b0;
            // Partial word dropped on deselect
            if (cs_high)
                bit_cnt <= '0;
            else if (sck_rise)
                bit_cnt <= bit_cnt + 5'd1;
            if (word_done)
                cmd_valid <= 1'b1;
        end
    end

    // Shifter and held word
    always_ff @(posedge clk)
    begin
        if (sck_rise && !cs_high)
            shift_q <= shift_next;
        if (word_done)
            cmd_data <= shift_next;
    end

    // Host may send while nothing is held
    assign serial_cts = ~cmd_valid;

endmodule

//--- design/frame_mem.sv
// On-chip frame store, one pixel per address
// One write port, one read port with one cycle of read latency
`timescale 1ns/10ps
`include "raster_settings.svh"

module frame_mem
    import raster_pkg::*;
(
    input  logic   clk,
    input  logic   wr_en,
    input  addr_t  wr_addr,
    input  pixel_t wr_data,
    input  logic   rd_en,
    input  addr_t  rd_addr,
    output pixel_t rd_data
);
    // Undefined until first clear
    pixel_t mem [`RASTER_PIXELS];

    // Write port
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Registered read, holds last value when idle
    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

//--- design/fill_engine.sv
// Command decoder and pixel painter for the frame memory
// Clears, fills rectangles and streams the frame to the panel on flush
`timescale 1ns/10ps
`include "raster_settings.svh"

module fill_engine
    import raster_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid,
    input  cmd_word_t cmd_data,
    output logic      cmd_ready,
    output logic      wr_en,
    output addr_t     wr_addr,
    output pixel_t    wr_data,
    output logic      rd_en,
    output addr_t     rd_addr,
    input  pixel_t    rd_data,
    output logic      pix_valid,
    output pixel_t    pix_data,
    output logic      pix_last,
    input  logic      pix_ready
);
    localparam int COL_W = $clog2(`RASTER_X_RES);
    localparam int ROW_W = $clog2(`RASTER_Y_RES);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CLEAR,
        S_RECT_WAIT,
        S_RECT_PAINT,
        S_FLUSH
    } state_e;

    state_e             state;
    logic [COL_W-1:0]   col_q;
    logic [COL_W-1:0]   x0_q;
    logic [COL_W-1:0]   x1_q;
    logic [ROW_W-1:0]   row_q;
    logic [ROW_W-1:0]   y0_q;
    logic [ROW_W-1:0]   y1_q;
    pixel_t             color_q;
    addr_t              rd_ptr;
    logic               rd_done;
    logic               rd_pend;
    logic               rd_issue;
    logic               painting;

    // Header only while idle, color word only in rect wait
    assign cmd_ready = (state == S_IDLE) || (state == S_RECT_WAIT);
    assign painting  = (state == S_CLEAR) || (state == S_RECT_PAINT);
    assign wr_en     = painting;
    assign wr_addr   = {row_q, col_q};
    assign wr_data   = color_q;

    // Read only when the output slot is free by the time data lands
    assign rd_issue = (state == S_FLUSH) && !rd_done && !rd_pend &&
                      (!pix_valid || pix_ready);
    assign rd_en    = rd_issue;
    assign rd_addr  = rd_ptr;

    ////////////////////////////////////////////////////////////
    // Main FSM and walk counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= S_IDLE;
            col_q   <= '0;
            row_q   <= '0;
            x0_q    <= '0;
            x1_q    <= '0;
            y0_q    <= '0;
            y1_q    <= '0;
            rd_ptr  <= '0;
            rd_done <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (cmd_valid)
                    begin
                        case (opcode_e'(cmd_data[31:24]))
                            OP_CLEAR:
                            begin
                                // Full-frame bounds, same walk as a rect
                                col_q <= '0;
                                row_q <= '0;
                                x0_q  <= '0;
                                x1_q  <= COL_W'(`RASTER_X_RES - 1);
                                y1_q  <= ROW_W'(`RASTER_Y_RES - 1);
                                state <= S_CLEAR;
                            end
                            OP_RECT:
                            begin
                                x0_q  <= cmd_data[23:20];
                                x1_q  <= cmd_data[19:16];
                                y0_q  <= cmd_data[14:12];
                                y1_q  <= cmd_data[10:8];
                                state <= S_RECT_WAIT;
                            end
                            OP_FLUSH:
                            begin
                                rd_ptr  <= '0;
                                rd_done <= 1'b0;
                                state   <= S_FLUSH;
                            end
                            // Unknown opcode, word consumed and dropped
                            default:
                                state <= S_IDLE;
                        endcase
                    end
                end
                S_RECT_WAIT:
                begin
                    if (cmd_valid)
                    begin
                        col_q <= x0_q;
                        row_q <= y0_q;
                        // Inverted bounds paint nothing
                        if (x1_q < x0_q || y1_q < y0_q)
                            state <= S_IDLE;
                        else
                            state <= S_RECT_PAINT;
                    end
                end
                S_CLEAR, S_RECT_PAINT:
                begin
                    if (col_q == x1_q)
                    begin
                        col_q <= x0_q;
                        if (row_q == y1_q)
                            state <= S_IDLE;
                        else
                            row_q <= row_q + 1'b1;
                    end
                    else
                    begin
                        col_q <= col_q + 1'b1;
                    end
                end
                S_FLUSH:
                begin
                    if (rd_issue)
                    begin
                        if (rd_ptr == addr_t'(`RASTER_PIXELS - 1))
                            rd_done <= 1'b1;
                        else
                            rd_ptr <= rd_ptr + 1'b1;
                    end
                    // Done once the last beat is taken
                    if (pix_valid && pix_ready && pix_last)
                        state <= S_IDLE;
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // Color from clear header or rect color word
    always_ff @(posedge clk)
    begin
        if (cmd_valid && cmd_ready)
            color_q <= cmd_data[15:0];
    end

    ////////////////////////////////////////////////////////////
    // Flush output slot
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_pend   <= 1'b0;
            pix_valid <= 1'b0;
            pix_last  <= 1'b0;
        end
        else
        begin
            rd_pend <= rd_issue;
            if (rd_pend)
            begin
                pix_valid <= 1'b1;
                // rd_done already set when the final read went out
                pix_last  <= rd_done;
            end
            else if (pix_ready)
            begin
                pix_valid <= 1'b0;
                pix_last  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_pend)
            pix_data <= rd_data;
    end

endmodule

//--- design/display_spi_tx.sv
// Panel SPI transmitter, one RGB565 pixel per 16 sck periods
// sck idles low, data shifts on falling sck, panel samples on rising sck
`timescale 1ns/10ps
`include "raster_settings.svh"

module display_spi_tx
    import raster_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   pix_valid,
    input  pixel_t pix_data,
    output logic   pix_ready,
    output logic   mosi,
    output logic   sck
);
    localparam int DIV   = `RASTER_SPI_DIV;
    localparam int DIV_W = $clog2(DIV + 1);

    logic             busy;
    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       bit_cnt;
    pixel_t           shreg;
    logic             half_done;

    // Accept only with an empty shifter
    assign pix_ready = ~busy;
    assign half_done = (div_cnt == DIV_W'(DIV - 1));
    // MSB first
    assign mosi      = shreg[15];

    ////////////////////////////////////////////////////////////
    // Clock divider and shifter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            sck     <= 1'b0;
            shreg   <= '0;
        end
        else if (!busy)
        begin
            if (pix_valid)
            begin
                // Load with sck low, first bit sits a full half period
                shreg   <= pix_data;
                busy    <= 1'b1;
                div_cnt <= '0;
                bit_cnt <= '0;
            end
        end
        else if (half_done)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
            // Falling edge, move to next bit
            if (sck)
            begin
                shreg   <= {shreg[14:0], 1'b0};
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd15)
                    busy <= 1'b0;
            end
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

//--- design/raster_top.sv
// Board-level top of the raster subsystem
// Reset sync, host-to-panel bypass mux and the four datapath blocks
`timescale 1ns/10ps

module raster_top
    import raster_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic serial_mosi,
    input  logic serial_sck,
    input  logic serial_cs,
    output logic serial_cts,
    input  logic bypass_sel,
    output logic display_mosi,
    output logic display_sck,
    output logic display_cs,
    output logic display_dc,
    output logic display_reset
);
    logic [1:0] rst_sync;
    logic       sys_rst_n;
    logic       bypass_q;

    logic       cmd_valid;
    logic       cmd_ready;
    cmd_word_t  cmd_data;
    logic       wr_en;
    addr_t      wr_addr;
    pixel_t     wr_data;
    logic       rd_en;
    addr_t      rd_addr;
    pixel_t     rd_data;
    logic       pix_valid;
    logic       pix_ready;
    pixel_t     pix_data;
    logic       tx_mosi;
    logic       tx_sck;

    ////////////////////////////////////////////////////////////
    // Reset sync and bypass select
    ////////////////////////////////////////////////////////////
    // Async assert, release after two clk edges
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rst_sync <= 2'b00;
        else
            rst_sync <= {rst_sync[0], 1'b1};
    end
    assign sys_rst_n = rst_sync[1];

    always_ff @(posedge clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            bypass_q <= 1'b0;
        else
            bypass_q <= bypass_sel;
    end

    // Host drives the panel directly in bypass
    assign display_mosi  = bypass_q ? serial_mosi : tx_mosi;
    assign display_sck   = bypass_q ? serial_sck  : tx_sck;
    assign display_cs    = bypass_q ? serial_cs   : 1'b0;
    // Pixel data only, never command mode
    assign display_dc    = 1'b1;
    assign display_reset = sys_rst_n;

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////
    serial_cmd_rx u_rx (
        .clk         (clk),
        .rst_n       (sys_rst_n),
        .serial_mosi (serial_mosi),
        .serial_sck  (serial_sck),
        .serial_cs   (serial_cs),
        .serial_cts  (serial_cts),
        .cmd_valid   (cmd_valid),
        .cmd_data    (cmd_data),
        .cmd_ready   (cmd_ready)
    );

    // pix_last not needed by this panel, left open
    fill_engine u_fill (
        .clk       (clk),
        .rst_n     (sys_rst_n),
        .cmd_valid (cmd_valid),
        .cmd_data  (cmd_data),
        .cmd_ready (cmd_ready),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_last  (),
        .pix_ready (pix_ready)
    );

    frame_mem u_mem (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    display_spi_tx u_tx (
        .clk       (clk),
        .rst_n     (sys_rst_n),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_ready (pix_ready),
        .mosi      (tx_mosi),
        .sck       (tx_sck)
    );

endmodule

//--- verif/raster_properties.sv
// Concurrent checks on the host word handshake and panel data pins
// Bound into raster_top, where the receiver port nets and bypass register live
`timescale 1ns/10ps

module raster_properties
    import raster_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      cmd_valid,
    input logic      cmd_ready,
    input cmd_word_t cmd_data,
    input logic      serial_cts,
    input logic      bypass_q,
    input logic      display_mosi,
    input logic      display_sck
);
    // Assertion failures so far
    int fail_count = 0;

    // Held word stays put until taken
    a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_data))
        else
        begin
            fail_count++;
            $error("cmd_valid dropped or cmd_data changed before cmd_ready");
        end

    // Host cleared to send again right after the word is taken
    a_cts_release: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && cmd_ready |=> serial_cts)
        else
        begin
            fail_count++;
            $error("serial_cts not high on the cycle after a word was accepted");
        end

    // Panel data only moves while its sck is low
    a_mosi_setup: assert property (@(posedge clk) disable iff (!rst_n)
        !bypass_q && display_sck |-> $stable(display_mosi))
        else
        begin
            fail_count++;
            $error("display_mosi changed while display_sck was high");
        end

endmodule

bind raster_top raster_properties u_props (
    .clk          (clk),
    .rst_n        (sys_rst_n),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd_data     (cmd_data),
    .serial_cts   (serial_cts),
    .bypass_q     (bypass_q),
    .display_mosi (display_mosi),
    .display_sck  (display_sck)
);

//--- verif/raster_tb.sv
// Testbench for raster_top, random host commands against a frame model
// Decodes the panel SPI stream back into pixels and compares in address order
`timescale 1ns/10ps
`include "raster_settings.svh"

module raster_tb
    import raster_pkg::*;
();
    localparam int SCK_HALF    = 8;
    localparam int CTS_TIMEOUT = 20000;
    localparam int PIX_TIMEOUT = 40000;
    localparam int TAIL_CYCLES = 200;

    logic clk;
    logic rst_n;
    logic serial_mosi;
    logic serial_sck;
    logic serial_cs;
    logic bypass_sel;
    logic serial_cts;
    logic display_mosi;
    logic display_sck;
    logic display_cs;
    logic display_dc;
    logic display_reset;

    // Frame model and pixel streams
    pixel_t ref_frame [`RASTER_PIXELS];
    pixel_t exp_pixels [$];
    pixel_t rx_pixels [$];

    // Panel decoder state
    logic [15:0] mon_shift    = '0;
    int          mon_bits     = 0;
    logic        mon_sck_prev = 1'b0;

    string cur_test;
    int    errors_in_test;
    int    total_errors;
    int    tests_run;
    int    tests_failed;

    raster_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .serial_mosi   (serial_mosi),
        .serial_sck    (serial_sck),
        .serial_cs     (serial_cs),
        .serial_cts    (serial_cts),
        .bypass_sel    (bypass_sel),
        .display_mosi  (display_mosi),
        .display_sck   (display_sck),
        .display_cs    (display_cs),
        .display_dc    (display_dc),
        .display_reset (display_reset)
    );

    // 40 ns clock
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Panel monitor
    ////////////////////////////////////////////////////////////
    // Rising display_sck seen in clk samples, bits MSB first
    always @(posedge clk)
    begin
        if (!rst_n || bypass_sel || display_cs)
        begin
            mon_bits = 0;
        end
        else if (display_sck && !mon_sck_prev)
        begin
            mon_shift = {mon_shift[14:0], display_mosi};
            mon_bits  = mon_bits + 1;
            if (mon_bits == 16)
            begin
                rx_pixels.push_back(mon_shift);
                mon_bits = 0;
            end
        end
        mon_sck_prev = display_sck;
    end

    ////////////////////////////////////////////////////////////
    // Bookkeeping
    ////////////////////////////////////////////////////////////
    task automatic start_test(input string name);
        cur_test       = name;
        errors_in_test = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors_in_test == 0)
        begin
            $display("test %s: ok", cur_test);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors_in_test);
        end
    endtask

    task automatic report_mismatch(input string what, input logic [15:0] exp_val,
                                   input logic [15:0] act_val);
        $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp_val, act_val);
        errors_in_test++;
        total_errors++;
    endtask

    // Ends the run from a stuck wait
    task automatic abort_run(input string reason);
        $display("Run stopped in test %s: %s", cur_test, reason);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic hold_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Frame model
    ////////////////////////////////////////////////////////////
    function automatic void model_clear(input pixel_t color);
        int i;
        for (i = 0; i < `RASTER_PIXELS; i++)
            ref_frame[i] = color;
    endfunction

    // Inclusive bounds, inverted ones give an empty loop
    function automatic void model_rect(input int x0, input int x1, input int y0,
                                       input int y1, input pixel_t color);
        int x;
        int y;
        for (y = y0; y <= y1; y++)
            for (x = x0; x <= x1; x++)
                ref_frame[y * `RASTER_X_RES + x] = color;
    endfunction

    ////////////////////////////////////////////////////////////
    // Host serial driver
    ////////////////////////////////////////////////////////////
    task automatic wait_cts();
        int n;
        n = 0;
        while (serial_cts !== 1'b1)
        begin
            @(negedge clk);
            n++;
            if (n > CTS_TIMEOUT)
                abort_run("serial_cts never went high");
        end
    endtask

    // MSB first, sampled by the DUT on rising sck
    task automatic send_word(input logic [31:0] w);
        int i;
        wait_cts();
        serial_cs = 1'b0;
        hold_cycles(SCK_HALF);
        for (i = 31; i >= 0; i--)
        begin
            serial_mosi = w[i];
            serial_sck  = 1'b0;
            hold_cycles(SCK_HALF);
            serial_sck  = 1'b1;
            hold_cycles(SCK_HALF);
        end
        serial_sck = 1'b0;
        hold_cycles(SCK_HALF);
        serial_cs = 1'b1;
        hold_cycles(SCK_HALF);
    endtask

    task automatic send_clear(input pixel_t color);
        model_clear(color);
        send_word({8'h01, 8'($urandom), color});
    endtask

    task automatic send_rect(input logic [3:0] x0, input logic [3:0] x1,
                             input logic [2:0] y0, input logic [2:0] y1,
                             input pixel_t color);
        logic [31:0] hdr;
        hdr = {8'h02, x0, x1, 1'b0, y0, 1'b0, y1, 8'h00};
        model_rect(x0, x1, y0, y1, color);
        send_word(hdr);
        // Upper half of the color word is don't care
        send_word({16'($urandom), color});
    endtask

    // Snapshot of the model at the point the flush is issued
    task automatic send_flush();
        int i;
        for (i = 0; i < `RASTER_PIXELS; i++)
            exp_pixels.push_back(ref_frame[i]);
        send_word({8'h03, 24'($urandom)});
    endtask

    task automatic compare_frames();
        int n;
        int i;
        n = 0;
        while (rx_pixels.size() < exp_pixels.size())
        begin
            @(negedge clk);
            n++;
            if (n > PIX_TIMEOUT)
                abort_run("panel stream stopped before the frame was complete");
        end
        // Any extra beat would show up in this gap
        hold_cycles(TAIL_CYCLES);
        if (rx_pixels.size() != exp_pixels.size())
            report_mismatch("pixel count", 16'(exp_pixels.size()), 16'(rx_pixels.size()));
        for (i = 0; i < exp_pixels.size() && i < rx_pixels.size(); i++)
        begin
            if (rx_pixels[i] !== exp_pixels[i])
                report_mismatch($sformatf("pixel %0d", i % `RASTER_PIXELS),
                                exp_pixels[i], rx_pixels[i]);
        end
        rx_pixels.delete();
        exp_pixels.delete();
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    task automatic test_clear_flush();
        start_test("clear_flush");
        send_clear(pixel_t'($urandom));
        send_flush();
        compare_frames();
        end_test();
    endtask

    task automatic test_random_rects();
        int k;
        int a;
        int b;
        int c;
        int d;
        start_test("random_rects");
        send_clear(pixel_t'($urandom));
        for (k = 0; k < 10; k++)
        begin
            a = $urandom_range(0, `RASTER_X_RES - 1);
            b = $urandom_range(0, `RASTER_X_RES - 1);
            c = $urandom_range(0, `RASTER_Y_RES - 1);
            d = $urandom_range(0, `RASTER_Y_RES - 1);
            // Ordered bounds so every rect paints
            send_rect((a < b) ? a : b, (a < b) ? b : a, (c < d) ? c : d, (c < d) ? d : c,
                      pixel_t'($urandom));
        end
        send_flush();
        compare_frames();
        end_test();
    endtask

    task automatic test_degenerate();
        int x0;
        int x1;
        logic [7:0] op;
        start_test("degenerate_unknown");
        send_clear(pixel_t'($urandom));
        x0 = $urandom_range(1, `RASTER_X_RES - 1);
        x1 = $urandom_range(0, x0 - 1);
        send_rect(x0, x1, 0, `RASTER_Y_RES - 1, pixel_t'($urandom));
        op = 8'($urandom_range(8'h04, 8'hff));
        send_word({op, 24'($urandom)});
        send_flush();
        compare_frames();
        end_test();
    endtask

    // Words queue up behind a running flush and must all land
    task automatic test_flow_control();
        int k;
        start_test("flow_control");
        send_clear(pixel_t'($urandom));
        send_flush();
        send_clear(pixel_t'($urandom));
        for (k = 0; k < 3; k++)
            send_rect(k, k + 5, k, k + 2, pixel_t'($urandom));
        send_flush();
        compare_frames();
        end_test();
    endtask

    task automatic test_bypass();
        int k;
        logic m;
        logic s;
        logic c;
        start_test("bypass");
        bypass_sel = 1'b1;
        hold_cycles(2);
        for (k = 0; k < 40; k++)
        begin
            m = 1'($urandom);
            s = 1'($urandom);
            c = 1'($urandom);
            serial_mosi = m;
            serial_sck  = s;
            serial_cs   = c;
            @(posedge clk);
            if (display_mosi !== m)
                report_mismatch("display_mosi", m, display_mosi);
            if (display_sck !== s)
                report_mismatch("display_sck", s, display_sck);
            if (display_cs !== c)
                report_mismatch("display_cs", c, display_cs);
            if (display_dc !== 1'b1)
                report_mismatch("display_dc", 1'b1, display_dc);
            @(negedge clk);
        end
        // Idle host lines, deselect drops any partial word
        serial_mosi = 1'b0;
        serial_sck  = 1'b0;
        serial_cs   = 1'b1;
        bypass_sel  = 1'b0;
        hold_cycles(4);
        end_test();
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        rst_n        = 1'b0;
        serial_mosi  = 1'b0;
        serial_sck   = 1'b0;
        serial_cs    = 1'b1;
        bypass_sel   = 1'b0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'ha53a_0b2f));

        // Reset state checked mid reset
        repeat (8) @(negedge clk);
        start_test("reset_state");
        if (display_sck !== 1'b0)
            report_mismatch("display_sck", 1'b0, display_sck);
        if (serial_cts !== 1'b1)
            report_mismatch("serial_cts", 1'b1, serial_cts);
        if (display_reset !== 1'b0)
            report_mismatch("display_reset", 1'b0, display_reset);
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        end_test();
        hold_cycles(8);

        test_clear_flush();
        test_random_rects();
        test_degenerate();
        test_flow_control();
        test_bypass();

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors,
                 u_dut.u_props.fail_count);
        if (tests_failed == 0 && u_dut.u_props.fail_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
design/raster_pkg.sv
design/serial_cmd_rx.sv
design/frame_mem.sv
design/fill_engine.sv
design/display_spi_tx.sv
design/raster_top.sv
verif/raster_properties.sv
verif/raster_tb.sv

//--- Bender.yml
package:
  name: raster

export_include_dirs:
  - include

sources:
  - files:
      - design/raster_pkg.sv
      - design/serial_cmd_rx.sv
      - design/frame_mem.sv
      - design/fill_engine.sv
      - design/display_spi_tx.sv
      - design/raster_top.sv
  - target: test
    files:
      - verif/raster_properties.sv
      - verif/raster_tb.sv
